// ==== logic/knight_pkg.sv ====
`default_nettype none

package knight_pkg;

  ////////////////////////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////////////////////////
  localparam int DUTY_W  = 11;   // duty word and period counter
  localparam int OMEGA_W = 16;   // signed wheel speed
  localparam int HEAD_W  = 20;   // signed platform heading
  localparam int POS_W   = 15;   // board coords, 4096 per square

  ////////////////////////////////////////////////////////////
  // physics constants
  ////////////////////////////////////////////////////////////
  localparam int OMEGA_MAX   = 32700;  // wheel speed clip
  localparam int TORQUE_DEAD = 32;     // friction band on |alpha|
  localparam int FWD_MIN     = 1000;   // both wheels above this to travel
  localparam int STEER_MIN   = 22000;  // speed sum needed for lateral IR

  // start pose is the center square, facing north
  localparam logic [POS_W-1:0]         START_XX      = 15'h2800;
  localparam logic [POS_W-1:0]         START_YY      = 15'h2800;
  localparam logic signed [HEAD_W-1:0] START_HEADING = 20'sh00000;

  // heading sectors, compared against heading[19:8]
  // north wraps through zero, so N_LO sits above N_HI
  localparam logic [11:0] SECT_N_LO = 12'hFB8;
  localparam logic [11:0] SECT_N_HI = 12'h048;
  localparam logic [11:0] SECT_S_LO = 12'h7B8;
  localparam logic [11:0] SECT_S_HI = 12'h848;
  localparam logic [11:0] SECT_E_LO = 12'hBB8;
  localparam logic [11:0] SECT_E_HI = 12'hC48;
  localparam logic [11:0] SECT_W_LO = 12'h3B8;
  localparam logic [11:0] SECT_W_HI = 12'h448;

  // center line windows on coord[11:0], bounds exclusive
  localparam logic [11:0] LINE_LO_A = 12'h3E0;
  localparam logic [11:0] LINE_HI_A = 12'h460;
  localparam logic [11:0] LINE_LO_B = 12'hBA0;
  localparam logic [11:0] LINE_HI_B = 12'hC20;

  // guard rail thresholds on the cross-track coord
  localparam logic [11:0] LANE_HI = 12'h8F0;
  localparam logic [11:0] LANE_LO = 12'h710;

endpackage

`default_nettype wire

// ==== logic/pwm_duty_meter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_duty_meter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          pwm,          // raw motor pwm level
  output logic [knight_pkg::DUTY_W-1:0] duty,         // high cycles of last period
  output logic                          period_done   // one cycle after wrap
);
  import knight_pkg::*;

  logic [DUTY_W-1:0] per_cnt;    // free running period position
  logic [DUTY_W-1:0] high_cnt;   // high cycles so far this period
  logic              wrap;

  assign wrap = &per_cnt;  // last cycle of the period

  ////////////////////////////////////////////////////////////
  // period and high-time counters
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      per_cnt <= '0;
    end else begin
      per_cnt <= per_cnt + 1'b1;  // wraps every 2048
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      high_cnt <= '0;
    end else if (wrap) begin
      high_cnt <= '0;  // start fresh for next period
    end else if (pwm) begin
      high_cnt <= high_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // hold the measurement and flag it
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      duty        <= '0;
      period_done <= 1'b0;
    end else begin
      if (wrap) duty <= high_cnt;  // holds until next wrap
      period_done <= wrap;
    end
  end

endmodule

`default_nettype wire

// ==== logic/wheel_dynamics.sv ====
`timescale 1ns/1ps
`default_nettype none

module wheel_dynamics (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  step,        // new duties available
  input  logic [knight_pkg::DUTY_W-1:0]         duty_fwd,
  input  logic [knight_pkg::DUTY_W-1:0]         duty_rev,
  output logic signed [knight_pkg::OMEGA_W-1:0] omega,       // wheel angular speed
  output logic                                  step_done    // omega just updated
);
  import knight_pkg::*;

  logic signed [DUTY_W:0]    torque;      // fwd minus rev, one extra bit for sign
  logic signed [13:0]        alpha_raw;   // before saturation
  logic signed [12:0]        alpha;       // saturated angular accel
  logic signed [OMEGA_W:0]   omega_int;   // integrated, one guard bit
  logic signed [OMEGA_W-1:0] omega_nxt;
  logic                      slipping;    // accel outside the dead band

  // linear torque model
  assign torque = $signed({1'b0, duty_fwd}) - $signed({1'b0, duty_rev});

  ////////////////////////////////////////////////////////////
  // angular acceleration: torque minus back-emf style drag
  ////////////////////////////////////////////////////////////
  assign alpha_raw = 14'(torque) - 14'(omega >>> 4) - 14'(omega >>> 6);

  always_comb begin
    if (alpha_raw[13] && !alpha_raw[12]) begin
      alpha = 13'sh1000;           // clamp at most negative
    end else if (!alpha_raw[13] && alpha_raw[12]) begin
      alpha = 13'sh0FFF;           // clamp at most positive
    end else begin
      alpha = alpha_raw[12:0];
    end
  end

  assign slipping = (alpha > TORQUE_DEAD) || (alpha < -TORQUE_DEAD);

  ////////////////////////////////////////////////////////////
  // speed integration with clip, else friction decay
  ////////////////////////////////////////////////////////////
  assign omega_int = (OMEGA_W+1)'(omega) + (OMEGA_W+1)'(alpha >>> 3);

  always_comb begin
    if (slipping) begin
      if (omega_int > OMEGA_MAX) begin
        omega_nxt = OMEGA_W'(OMEGA_MAX);
      end else if (omega_int < -OMEGA_MAX) begin
        omega_nxt = OMEGA_W'(-OMEGA_MAX);
      end else begin
        omega_nxt = omega_int[OMEGA_W-1:0];
      end
    end else begin
      omega_nxt = omega - (omega >>> 6);  // friction takes 1/64
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      omega     <= '0;
      step_done <= 1'b0;
    end else begin
      if (step) omega <= omega_nxt;
      step_done <= step;  // lines up with new omega
    end
  end

endmodule

`default_nettype wire

// ==== logic/platform_integrator.sv ====
`timescale 1ns/1ps
`default_nettype none

module platform_integrator (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  step,        // wheel speeds updated
  input  logic signed [knight_pkg::OMEGA_W-1:0] omega_lft,
  input  logic signed [knight_pkg::OMEGA_W-1:0] omega_rght,
  output logic signed [knight_pkg::HEAD_W-1:0]  heading,
  output logic [knight_pkg::POS_W-1:0]          xx,
  output logic [knight_pkg::POS_W-1:0]          yy,
  output logic                                  lft_ir_n,    // guard rail on left
  output logic                                  cntr_ir_n,   // over a center line
  output logic                                  rght_ir_n,   // guard rail on right
  output logic                                  pose_vld
);
  import knight_pkg::*;

  logic signed [OMEGA_W-1:0] head_rate;    // platform angular speed
  logic signed [OMEGA_W:0]   omega_sum;    // positive when driving forward
  logic signed [HEAD_W-1:0]  heading_nxt;
  logic [11:0]               sector;       // coarse heading
  logic [POS_W-1:0]          advance;      // distance per step
  logic                      moving;
  logic                      steering;
  logic                      in_n, in_s, in_e, in_w;
  logic [POS_W-1:0]          xx_nxt, yy_nxt;
  logic [11:0]               xx_lo, yy_lo; // position within a square
  logic                      lft_nxt, rght_nxt;
  logic                      on_line;

  function automatic logic in_window(input logic [11:0] v);
    in_window = ((v > LINE_LO_A) && (v < LINE_HI_A)) ||
                ((v > LINE_LO_B) && (v < LINE_HI_B));
  endfunction

  ////////////////////////////////////////////////////////////
  // heading integration
  ////////////////////////////////////////////////////////////
  assign head_rate   = (omega_rght >>> 1) - (omega_lft >>> 1);  // ccw positive
  assign heading_nxt = heading + HEAD_W'(head_rate >>> 7);

  assign omega_sum = omega_lft + omega_rght;                    // 17 bit context
  assign moving    = (omega_lft > FWD_MIN) && (omega_rght > FWD_MIN);
  assign steering  = omega_sum > STEER_MIN;
  assign advance   = POS_W'(omega_sum[OMEGA_W:13]);             // top 4 bits only

  // sector decode uses the freshly integrated heading
  assign sector = heading_nxt[HEAD_W-1:HEAD_W-12];
  assign in_n   = (sector >= SECT_N_LO) || (sector <= SECT_N_HI);  // wraps zero
  assign in_s   = (sector >= SECT_S_LO) && (sector <= SECT_S_HI);
  assign in_e   = (sector >= SECT_E_LO) && (sector <= SECT_E_HI);
  assign in_w   = (sector >= SECT_W_LO) && (sector <= SECT_W_HI);

  ////////////////////////////////////////////////////////////
  // travel along the sector axis
  ////////////////////////////////////////////////////////////
  always_comb begin
    xx_nxt = xx;
    yy_nxt = yy;
    if (moving) begin
      if (in_n) begin
        yy_nxt = yy + advance;
      end else if (in_s) begin
        yy_nxt = yy - advance;
      end else if (in_e) begin
        xx_nxt = xx + advance;
      end else if (in_w) begin
        xx_nxt = xx - advance;
      end
      // off-axis headings do not translate
    end
  end

  assign xx_lo = xx_nxt[11:0];
  assign yy_lo = yy_nxt[11:0];

  ////////////////////////////////////////////////////////////
  // lateral IR, side depends on direction of travel
  ////////////////////////////////////////////////////////////
  always_comb begin
    lft_nxt  = 1'b1;  // inactive unless a rail is seen
    rght_nxt = 1'b1;
    if (moving && steering) begin
      if (in_n) begin
        rght_nxt = !(xx_lo > LANE_HI);  // drifted east
        lft_nxt  = !(xx_lo < LANE_LO);
      end else if (in_s) begin
        lft_nxt  = !(xx_lo > LANE_HI);  // mirrored facing south
        rght_nxt = !(xx_lo < LANE_LO);
      end else if (in_e) begin
        lft_nxt  = !(yy_lo > LANE_HI);
        rght_nxt = !(yy_lo < LANE_LO);
      end else if (in_w) begin
        rght_nxt = !(yy_lo > LANE_HI);
        lft_nxt  = !(yy_lo < LANE_LO);
      end
    end
  end

  assign on_line = in_window(xx_lo) || in_window(yy_lo);

  ////////////////////////////////////////////////////////////
  // pose registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      heading   <= START_HEADING;
      xx        <= START_XX;
      yy        <= START_YY;
      lft_ir_n  <= 1'b1;
      cntr_ir_n <= 1'b1;
      rght_ir_n <= 1'b1;
      pose_vld  <= 1'b0;
    end else begin
      if (step) begin
        heading   <= heading_nxt;
        xx        <= xx_nxt;
        yy        <= yy_nxt;
        lft_ir_n  <= lft_nxt;
        cntr_ir_n <= !on_line;  // active low
        rght_ir_n <= rght_nxt;
      end
      pose_vld <= step;
    end
  end

endmodule

`default_nettype wire

// ==== logic/knight_physics_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module knight_physics_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  lft_pwm1,    // left forward
  input  logic                                  lft_pwm2,    // left reverse
  input  logic                                  rght_pwm1,   // right forward
  input  logic                                  rght_pwm2,   // right reverse
  output logic                                  lft_ir_n,
  output logic                                  cntr_ir_n,
  output logic                                  rght_ir_n,
  output logic signed [knight_pkg::HEAD_W-1:0]  heading,
  output logic [knight_pkg::POS_W-1:0]          xx,
  output logic [knight_pkg::POS_W-1:0]          yy,
  output logic signed [knight_pkg::OMEGA_W-1:0] omega_lft,
  output logic signed [knight_pkg::OMEGA_W-1:0] omega_rght,
  output logic                                  pose_vld
);
  import knight_pkg::*;

  logic [DUTY_W-1:0] duty_l1, duty_l2;   // left fwd / rev
  logic [DUTY_W-1:0] duty_r1, duty_r2;   // right fwd / rev
  logic              period_done;        // shared physics tick
  logic              wheel_done;

  ////////////////////////////////////////////////////////////
  // duty meters, all share the same period phase
  ////////////////////////////////////////////////////////////
  pwm_duty_meter mtr_l1_i (.clk(clk), .rst_n(rst_n), .pwm(lft_pwm1),
                           .duty(duty_l1), .period_done(period_done));
  pwm_duty_meter mtr_l2_i (.clk(clk), .rst_n(rst_n), .pwm(lft_pwm2),
                           .duty(duty_l2), .period_done());
  pwm_duty_meter mtr_r1_i (.clk(clk), .rst_n(rst_n), .pwm(rght_pwm1),
                           .duty(duty_r1), .period_done());
  pwm_duty_meter mtr_r2_i (.clk(clk), .rst_n(rst_n), .pwm(rght_pwm2),
                           .duty(duty_r2), .period_done());

  ////////////////////////////////////////////////////////////
  // wheels side by side
  ////////////////////////////////////////////////////////////
  wheel_dynamics wheel_lft_i (.clk(clk), .rst_n(rst_n), .step(period_done),
                              .duty_fwd(duty_l1), .duty_rev(duty_l2),
                              .omega(omega_lft), .step_done(wheel_done));
  wheel_dynamics wheel_rght_i (.clk(clk), .rst_n(rst_n), .step(period_done),
                               .duty_fwd(duty_r1), .duty_rev(duty_r2),
                               .omega(omega_rght), .step_done());

  // platform combines both wheels
  platform_integrator plat_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .step       (wheel_done),
    .omega_lft  (omega_lft),
    .omega_rght (omega_rght),
    .heading    (heading),
    .xx         (xx),
    .yy         (yy),
    .lft_ir_n   (lft_ir_n),
    .cntr_ir_n  (cntr_ir_n),
    .rght_ir_n  (rght_ir_n),
    .pose_vld   (pose_vld)
  );

endmodule

`default_nettype wire

// ==== bench/knight_physics_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module knight_physics_tb;
  import knight_pkg::*;

  localparam int PERIOD     = 2048;    // pwm period in clocks
  localparam int MAX_CYCLES = 160000;  // ~70 periods of tests plus margin

  logic clk, rst_n;
  logic lft_pwm1, lft_pwm2, rght_pwm1, rght_pwm2;
  logic lft_ir_n, cntr_ir_n, rght_ir_n, pose_vld;
  logic signed [HEAD_W-1:0]  heading;
  logic [POS_W-1:0]          xx, yy;
  logic signed [OMEGA_W-1:0] omega_lft, omega_rght;

  int nxt_duty [4];  // l1 l2 r1 r2 for the next period
  int act_duty [4];  // being driven this period
  int msr_duty [4];  // period the DUT just measured
  int phase = 0;
  int cyc = 0;
  logic [31:0] lfsr;
  int m_om_l, m_om_r, m_head, m_xx, m_yy;  // reference model state
  int m_lft, m_cntr, m_rght;

  knight_physics_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // stimulus and timeout handling
  ////////////////////////////////////////////////////////////
  task automatic drive_pwms(input int ph);
    lft_pwm1  <= (ph < act_duty[0]);  // high for first duty cycles
    lft_pwm2  <= (ph < act_duty[1]);
    rght_pwm1 <= (ph < act_duty[2]);
    rght_pwm2 <= (ph < act_duty[3]);
  endtask

  // phase tracks the meter's period counter after each edge
  always @(posedge clk) begin
    if (rst_n) begin
      phase = (phase + 1) % PERIOD;
      if (phase == 0) begin
        msr_duty = act_duty;  // finished period goes to the wheels
        act_duty = nxt_duty;
      end
      drive_pwms(phase);
    end
  end

  task automatic fail_with(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= MAX_CYCLES) fail_with("timeout: pose_vld never arrived before the cycle limit");
  end

  task automatic compare_int(input string name, input int got, input int exp);
    assert (got == exp) else
      fail_with($sformatf("mismatch at %0t ns: %s dut=%0d expected=%0d", $time, name, got, exp));
  endtask

  task automatic confirm(input logic ok, input string what);
    assert (ok) else fail_with($sformatf("error at %0t ns: %s", $time, what));
  endtask

  // galois lfsr stepped once per random bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model of wheels and platform
  ////////////////////////////////////////////////////////////
  function automatic int wheel_next(input int om, input int fwd, input int rev);
    int acc;
    int nx;
    acc = fwd - rev - (om >>> 4) - (om >>> 6);
    if (acc > 4095) acc = 4095;      // 13 bit signed range
    if (acc < -4096) acc = -4096;
    if (acc > TORQUE_DEAD || acc < -TORQUE_DEAD) begin
      nx = om + (acc >>> 3);
      if (nx > OMEGA_MAX) nx = OMEGA_MAX;
      if (nx < -OMEGA_MAX) nx = -OMEGA_MAX;
    end else begin
      nx = om - (om >>> 6);          // friction only
    end
    return nx;
  endfunction

  function automatic logic line_hit(input int v);
    return (v > LINE_LO_A && v < LINE_HI_A) || (v > LINE_LO_B && v < LINE_HI_B);
  endfunction

  task automatic model_step();
    int sect, sum, adv, xlo, ylo;
    logic n, s, e, w, mov;
    m_om_l = wheel_next(m_om_l, msr_duty[0], msr_duty[1]);
    m_om_r = wheel_next(m_om_r, msr_duty[2], msr_duty[3]);
    m_head = m_head + (((m_om_r >>> 1) - (m_om_l >>> 1)) >>> 7);
    if (m_head >= 524288) m_head = m_head - 1048576;  // 20 bit wrap
    if (m_head < -524288) m_head = m_head + 1048576;
    sect = (m_head >>> 8) & 12'hFFF;
    n = (sect >= SECT_N_LO) || (sect <= SECT_N_HI);
    s = (sect >= SECT_S_LO) && (sect <= SECT_S_HI);
    e = (sect >= SECT_E_LO) && (sect <= SECT_E_HI);
    w = (sect >= SECT_W_LO) && (sect <= SECT_W_HI);
    mov = (m_om_l > FWD_MIN) && (m_om_r > FWD_MIN);
    sum = m_om_l + m_om_r;
    adv = sum >>> 13;
    if (mov && n) m_yy = m_yy + adv;
    else if (mov && s) m_yy = m_yy - adv;
    else if (mov && e) m_xx = m_xx + adv;
    else if (mov && w) m_xx = m_xx - adv;
    m_xx = m_xx & 32'h7FFF;
    m_yy = m_yy & 32'h7FFF;
    xlo = m_xx & 12'hFFF;
    ylo = m_yy & 12'hFFF;
    m_lft = 1;
    m_rght = 1;
    if (mov && sum > STEER_MIN) begin
      if (n) begin
        m_rght = !(xlo > LANE_HI);
        m_lft  = !(xlo < LANE_LO);
      end else if (s) begin
        m_lft  = !(xlo > LANE_HI);
        m_rght = !(xlo < LANE_LO);
      end else if (e) begin
        m_lft  = !(ylo > LANE_HI);
        m_rght = !(ylo < LANE_LO);
      end else if (w) begin
        m_rght = !(ylo > LANE_HI);
        m_lft  = !(ylo < LANE_LO);
      end
    end
    m_cntr = !(line_hit(xlo) || line_hit(ylo));
  endtask

  // wait for the next pose update then step the model and compare every output
  task automatic next_pose();
    @(negedge clk);
    while (!pose_vld) @(negedge clk);
    model_step();
    compare_int("omega_lft", omega_lft, m_om_l);
    compare_int("omega_rght", omega_rght, m_om_r);
    compare_int("heading", heading, m_head);
    compare_int("xx", xx, m_xx);
    compare_int("yy", yy, m_yy);
    compare_int("lft_ir_n", lft_ir_n, m_lft);
    compare_int("cntr_ir_n", cntr_ir_n, m_cntr);
    compare_int("rght_ir_n", rght_ir_n, m_rght);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic reset_state();
    @(negedge clk);
    compare_int("heading", heading, START_HEADING);
    compare_int("xx", xx, START_XX);
    compare_int("yy", yy, START_YY);
    compare_int("omega_lft", omega_lft, 0);
    compare_int("omega_rght", omega_rght, 0);
    confirm(lft_ir_n && cntr_ir_n && rght_ir_n, "an IR output is active after reset");
    for (int i = 0; i < PERIOD; i++) begin
      @(negedge clk);
      confirm(!pose_vld, "pose_vld pulsed before the first pwm period ended");
    end
  endtask

  task automatic straight_drive();
    int d;
    int y0;
    take_bits(10, d);
    d = d + 1024;
    nxt_duty = '{d, 0, d, 0};
    y0 = m_yy;
    repeat (12) begin
      next_pose();
      compare_int("omega_rght", omega_rght, m_om_l);  // equal duties give equal speeds
      compare_int("heading", heading, START_HEADING);
      compare_int("xx", xx, START_XX);
      confirm(int'(yy) >= y0, "yy went backward on a straight northward drive");
      y0 = m_yy;
    end
  endtask

  task automatic pivot_turn();
    int dl, dr, x0, y0;
    take_bits(10, dl);
    take_bits(10, dr);
    nxt_duty = '{0, dl + 1024, dr + 1024, 0};  // left wheel reverse and right wheel forward
    x0 = m_xx;
    y0 = m_yy;
    repeat (8) begin
      next_pose();
      compare_int("xx", xx, x0);
      compare_int("yy", yy, y0);
      confirm(lft_ir_n && rght_ir_n, "a lateral IR output went low while pivoting");
    end
    confirm(heading > START_HEADING, "heading did not turn positive during the pivot");
  endtask

  task automatic coast_down();
    int l_prev, r_prev, l_now, r_now;
    nxt_duty = '{0, 0, 0, 0};
    next_pose();  // period in flight still carries the pivot duties
    l_prev = (m_om_l < 0) ? -m_om_l : m_om_l;
    r_prev = (m_om_r < 0) ? -m_om_r : m_om_r;
    repeat (7) begin
      next_pose();
      l_now = (omega_lft < 0) ? -omega_lft : omega_lft;
      r_now = (omega_rght < 0) ? -omega_rght : omega_rght;
      confirm(l_now <= l_prev && r_now <= r_prev, "wheel speed grew while coasting");
      l_prev = (m_om_l < 0) ? -m_om_l : m_om_l;
      r_prev = (m_om_r < 0) ? -m_om_r : m_om_r;
    end
  endtask

  task automatic full_duty_run();
    int y0;
    nxt_duty = '{2047, 0, 2047, 0};  // full forward on both wheels
    y0 = m_yy;
    repeat (40) begin
      next_pose();
      confirm(omega_lft <= OMEGA_MAX && omega_rght <= OMEGA_MAX, "omega above clip limit");
    end
    confirm(omega_lft > 4096 && omega_rght > 4096, "wheels did not spin up at full duty");
    confirm(int'(yy) > y0, "robot did not travel north at full duty");
  endtask

  initial begin
    lfsr = 32'h6e1b_fcd7;
    rst_n     <= 1'b0;
    lft_pwm1  <= 1'b0;
    lft_pwm2  <= 1'b0;
    rght_pwm1 <= 1'b0;
    rght_pwm2 <= 1'b0;
    nxt_duty = '{0, 0, 0, 0};
    act_duty = '{0, 0, 0, 0};
    msr_duty = '{0, 0, 0, 0};
    m_om_l = 0;
    m_om_r = 0;
    m_head = START_HEADING;
    m_xx   = START_XX;
    m_yy   = START_YY;
    m_lft  = 1;
    m_cntr = 1;
    m_rght = 1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    reset_state();
    straight_drive();
    pivot_turn();
    coast_down();
    full_duty_run();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/knight_pkg.sv
logic/pwm_duty_meter.sv
logic/wheel_dynamics.sv
logic/platform_integrator.sv
logic/knight_physics_top.sv
bench/knight_physics_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the knight physics testbench with verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module knight_physics_tb -o knight_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/knight_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
  echo "FAIL (see $LOG)"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "PASS"
exit 0
